//--- Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert
LINTFLAGS = --lint-only
TOP       = orbTb
FILELIST  = project.f
OBJDIR    = obj_dir
SIMARGS   = +verilator+error+limit+100
PASSTEXT  = === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIMARGS))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)

//--- framePacker.sv
`timescale 1ns/1ps

module framePacker (
	input  logic               clk100MHz,
	input  logic               rstN,
	input  orbPkg::orbSample_t fast0,
	input  orbPkg::orbSample_t fast1,
	input  orbPkg::orbSample_t slow0,
	input  orbPkg::orbSample_t slow1,
	input  logic [3:0]         emptyFlags, // {slow1, slow0, fast1, fast0}
	output logic [3:0]         popStrobes, // same order as emptyFlags
	output orbPkg::bufWrite_t  bufWr
);
	import orbPkg::*;

	typedef enum logic {sPick, sWrite} packState_t;

	packState_t state;
	orbSample_t heads [4]; // index 0 is highest priority
	orbSample_t held;      // sample being written
	logic       pickHit;
	logic [1:0] pickIdx;

	assign heads[0] = fast0;
	assign heads[1] = fast1;
	assign heads[2] = slow0;
	assign heads[3] = slow1;

	// fixed priority, lowest index wins
	always_comb begin
		pickHit = 1'b0;
		pickIdx = 2'd0;
		for (int i = 3; i >= 0; i--) begin
			if (!emptyFlags[i]) begin
				pickHit = 1'b1;
				pickIdx = 2'(i);
			end
		end
	end

	always_ff @(posedge clk100MHz) begin
		if (!rstN) begin
			state      <= sPick;
			popStrobes <= '0;
			bufWr      <= '0;
		end else begin
			popStrobes <= '0;
			bufWr.we   <= 1'b0;
			case (state)
				sPick: begin
					if (pickHit) begin
						popStrobes[pickIdx] <= 1'b1; // fifo advances during write state
						state               <= sWrite;
					end
				end
				sWrite: begin
					bufWr.we   <= 1'b1;
					bufWr.addr <= held.slot;
					bufWr.data <= held.data;
					state      <= sPick; // flags settled by next pick
				end
				default: state <= sPick;
			endcase
		end
	end

	always_ff @(posedge clk100MHz) begin
		if (state == sPick && pickHit)
			held <= heads[pickIdx]; // capture before pop
	end

endmodule

//--- frameTimer.sv
`timescale 1ns/1ps
`include "orbTelemetry_defines.svh"

module frameTimer (
	input  logic                      clk100MHz,
	input  logic                      rstN,
	output logic [`ORB_SLOT_BITS-1:0] rdAddr,
	output logic                      rdEn,
	output logic                      bankSwap,
	output logic                      wordStrobe,
	output logic                      frameStart
);
	localparam int WordClks = `ORB_WORD_CLKS;
	localparam int CntW     = $clog2(WordClks);
	localparam int LastSlot = `ORB_FRAME_WORDS - 1;

	logic [CntW-1:0]           wordCnt; // cycles within word period
	logic [`ORB_SLOT_BITS-1:0] slotCnt; // next slot to read

	assign rdAddr = slotCnt;

	always_ff @(posedge clk100MHz) begin
		if (!rstN) begin
			wordCnt    <= '0;
			slotCnt    <= '0; // frame restarts at slot 0
			rdEn       <= 1'b0;
			bankSwap   <= 1'b0;
			wordStrobe <= 1'b0;
			frameStart <= 1'b0;
		end else begin
			if (wordCnt == CntW'(WordClks - 1))
				wordCnt <= '0;
			else
				wordCnt <= wordCnt + 1'b1;
			rdEn <= (wordCnt == CntW'(WordClks - 1)); // one read per period

			if (rdEn) begin
				if (slotCnt == `ORB_SLOT_BITS'(LastSlot))
					slotCnt <= '0;
				else
					slotCnt <= slotCnt + 1'b1;
			end

			// swap right after last slot read
			bankSwap   <= rdEn && (slotCnt == `ORB_SLOT_BITS'(LastSlot));
			// delayed one cycle to meet registered ram data
			wordStrobe <= rdEn;
			frameStart <= rdEn && (slotCnt == '0);
		end
	end

endmodule

//--- orbPkg.sv
`include "orbTelemetry_defines.svh"

package orbPkg;

	// one measurement with its frame slot, fifo payload
	typedef struct packed {
		logic [`ORB_SLOT_BITS-1:0] slot; // target slot in frame
		logic [`ORB_DATA_BITS-1:0] data; // 12-bit measurement
	} orbSample_t;

	// packer to frame buffer write port
	typedef struct packed {
		logic                      we;   // single-cycle write strobe
		logic [`ORB_SLOT_BITS-1:0] addr; // slot in write bank
		logic [`ORB_DATA_BITS-1:0] data; // word to store
	} bufWrite_t;

endpackage

//--- orbTb.sv
`timescale 1ns/1ps
`include "orbTelemetry_defines.svh"

module orbTb;
	localparam int ResetClks   = 16;
	localparam int FrameClks   = `ORB_FRAME_WORDS * `ORB_WORD_CLKS;
	localparam int TestFrames  = 6; // frames read out before the last check
	localparam int TimeoutClks = ResetClks + `ORB_WORD_CLKS + 1 + (TestFrames + 1) * FrameClks;

	logic                      clk100MHz;
	logic                      rstN;
	logic                      rxLine0;
	logic                      rxLine1;
	logic [`ORB_DATA_BITS-1:0] orbWord;
	logic                      wordStrobe;
	logic                      frameStart;

	logic [`ORB_DATA_BITS-1:0] curFrame [`ORB_FRAME_WORDS];  // expected in frame being read
	logic [`ORB_DATA_BITS-1:0] nextFrame [`ORB_FRAME_WORDS]; // filled by traffic sent now
	int                        slotIdx = `ORB_FRAME_WORDS;   // no frame seen yet
	int                        framesSeen = 0;
	integer                    seed;

	orbTop UUT (
		.clk100MHz(clk100MHz),
		.rstN(rstN),
		.rxLine0(rxLine0),
		.rxLine1(rxLine1),
		.orbWord(orbWord),
		.wordStrobe(wordStrobe),
		.frameStart(frameStart)
	);

	initial begin
		clk100MHz = 1'b1; // first edge is a falling one
		forever #5 clk100MHz = ~clk100MHz;
	end

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic waitFrame(input int n);
		wait (framesSeen >= n); // monitor has rolled the model over
	endtask

	task automatic clearNextFrame();
		for (int i = 0; i < `ORB_FRAME_WORDS; i++)
			nextFrame[i] = '0;
	endtask

	// one 8N1 character per active line, both lines in step
	task automatic shiftBytes(input logic [7:0] byte0, input logic [7:0] byte1,
			input logic [1:0] active, input logic badStop);
		logic [9:0] bits0;
		logic [9:0] bits1;
		bits0 = {~badStop, byte0, 1'b0}; // stop, data lsb first, start
		bits1 = {~badStop, byte1, 1'b0};
		for (int i = 0; i < 10; i++) begin
			rxLine0 = active[0] ? bits0[i] : 1'b1;
			rxLine1 = active[1] ? bits1[i] : 1'b1;
			repeat (`ORB_CLKS_PER_BIT) @(negedge clk100MHz);
		end
		rxLine0 = 1'b1;
		rxLine1 = 1'b1;
	endtask

	// random packet per active channel, expected words go to the next frame
	task automatic sendPackets(input logic [1:0] active);
		logic [`ORB_DATA_BITS-1:0] words [2][`ORB_PACKET_WORDS];
		logic [3:0]                junk [2][`ORB_PACKET_WORDS]; // high byte upper nibble
		logic [31:0]               r;
		for (int ch = 0; ch < 2; ch++) begin
			for (int w = 0; w < `ORB_PACKET_WORDS; w++) begin
				r             = $random(seed);
				words[ch][w]  = r[11:0];
				junk[ch][w]   = r[19:16];
				if (active[ch])
					nextFrame[ch * `ORB_CHAN_SLOTS + w] = r[11:0]; // slot = base + index
			end
		end
		for (int w = 0; w < `ORB_PACKET_WORDS; w++) begin
			shiftBytes(words[0][w][7:0], words[1][w][7:0], active, 1'b0); // low byte first
			shiftBytes({junk[0][w], words[0][w][11:8]}, {junk[1][w], words[1][w][11:8]},
				active, 1'b0);
		end
	endtask

	task automatic sendBadByte();
		logic [31:0] r;
		r = $random(seed);
		shiftBytes(r[7:0], 8'hff, 2'b01, 1'b1); // channel 0, stop bit low
		repeat (2 * `ORB_CLKS_PER_BIT) @(negedge clk100MHz); // idle so next start is an edge
	endtask

	// outputs settle after the rising edge, read them on the falling one
	always @(negedge clk100MHz) begin
		if (UUT.uProps.anyFail)
			abortRun("timing property of word strobe or frame start failed");
		if (rstN && wordStrobe) begin
			if (frameStart) begin
				curFrame = nextFrame; // last frame's writes become visible
				slotIdx  = 0;
			end
			if (slotIdx >= `ORB_FRAME_WORDS) begin
				abortRun("word strobe past the last slot without a frame start");
			end else begin
				assert (orbWord == curFrame[slotIdx])
					else abortRun($sformatf("mismatch at %0t ns: slot %0d expected 0x%03h got 0x%03h",
						$time, slotIdx, curFrame[slotIdx], orbWord));
				slotIdx = slotIdx + 1;
			end
			if (frameStart)
				framesSeen = framesSeen + 1;
		end
	end

	initial begin
		repeat (TimeoutClks) @(posedge clk100MHz);
		abortRun($sformatf("watchdog expired after %0d cycles, frames did not complete",
			TimeoutClks));
	end

	initial begin
		seed    = 74459;
		rstN    = 1'b0;
		rxLine0 = 1'b1; // idle line high
		rxLine1 = 1'b1;
		clearNextFrame();
		repeat (ResetClks) @(negedge clk100MHz);
		rstN = 1'b1;

		waitFrame(1); // lone packet on channel 0
		clearNextFrame();
		sendPackets(2'b01);

		waitFrame(2); // both channels at once
		clearNextFrame();
		sendPackets(2'b11);

		waitFrame(3); // quiet frame, next one must read all zero
		clearNextFrame();

		waitFrame(4); // framing error then a good packet
		clearNextFrame();
		sendBadByte();
		sendPackets(2'b01);

		waitFrame(5);
		clearNextFrame();

		waitFrame(TestFrames + 1); // last frame fully checked
		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- orbTelemetry_defines.svh
`ifndef ORB_TELEMETRY_DEFINES_SVH
`define ORB_TELEMETRY_DEFINES_SVH

// serial link timing
`define ORB_CLKS_PER_BIT 16 // clk100MHz cycles per uart bit, sim rate

// frame geometry
`define ORB_WORD_CLKS    64 // cycles between output words
`define ORB_FRAME_WORDS  32 // slots per frame
`define ORB_SLOT_BITS    5  // slot address width
`define ORB_DATA_BITS    12 // measurement word width
`define ORB_CHAN_SLOTS   16 // slots owned by each channel

// packet layout
`define ORB_PACKET_WORDS 4  // words per packet, two bytes each
`define ORB_FAST_WORDS   2  // leading words that go to the fast stream

// buffering
`define ORB_FIFO_DEPTH   8  // entries per stream fifo

`endif

//--- orbTop.sv
`timescale 1ns/1ps
`include "orbTelemetry_defines.svh"

module orbTop (
	input  logic                      clk100MHz,
	input  logic                      rstN,
	input  logic                      rxLine0,
	input  logic                      rxLine1,
	output logic [`ORB_DATA_BITS-1:0] orbWord,
	output logic                      wordStrobe,
	output logic                      frameStart
);
	import orbPkg::*;

	logic [1:0]                rxLines;
	logic [1:0]                byteStrobe;
	logic [7:0]                rxData [2];
	logic [1:0]                frameErr;
	logic [1:0]                fastPush, slowPush;
	orbSample_t                sample [2];     // assembler output per channel
	orbSample_t                fastHead [2];
	orbSample_t                slowHead [2];
	logic [1:0]                fastEmpty, slowEmpty;
	logic [3:0]                popStrobes;     // {slow1, slow0, fast1, fast0}
	bufWrite_t                 bufWr;
	logic [`ORB_SLOT_BITS-1:0] rdAddr;
	logic                      rdEn;
	logic                      bankSwap;

	assign rxLines = {rxLine1, rxLine0};

	for (genvar ch = 0; ch < 2; ch++) begin : gChan
		uartRx uRx (
			.clk100MHz(clk100MHz), .rstN(rstN), .rxLine(rxLines[ch]),
			.byteStrobe(byteStrobe[ch]), .rxData(rxData[ch]), .frameErr(frameErr[ch])
		);
		wordAssembler #(.channel(ch)) uAsm (
			.clk100MHz(clk100MHz), .rstN(rstN), .byteStrobe(byteStrobe[ch]),
			.rxData(rxData[ch]), .frameErr(frameErr[ch]), .fastPush(fastPush[ch]),
			.slowPush(slowPush[ch]), .sample(sample[ch])
		);
		// both fifos see the same sample, push picks one
		wordFifo uFastFifo (
			.clk100MHz(clk100MHz), .rstN(rstN), .push(fastPush[ch]), .pushData(sample[ch]),
			.pop(popStrobes[ch]), .head(fastHead[ch]), .empty(fastEmpty[ch])
		);
		wordFifo uSlowFifo (
			.clk100MHz(clk100MHz), .rstN(rstN), .push(slowPush[ch]), .pushData(sample[ch]),
			.pop(popStrobes[2 + ch]), .head(slowHead[ch]), .empty(slowEmpty[ch])
		);
	end

	framePacker uPacker (
		.clk100MHz(clk100MHz), .rstN(rstN), .fast0(fastHead[0]), .fast1(fastHead[1]),
		.slow0(slowHead[0]), .slow1(slowHead[1]), .emptyFlags({slowEmpty, fastEmpty}),
		.popStrobes(popStrobes), .bufWr(bufWr)
	);

	frameTimer uTimer (
		.clk100MHz(clk100MHz), .rstN(rstN), .rdAddr(rdAddr), .rdEn(rdEn),
		.bankSwap(bankSwap), .wordStrobe(wordStrobe), .frameStart(frameStart)
	);

	pingPongRam uRam (
		.clk100MHz(clk100MHz), .rstN(rstN), .bufWr(bufWr), .rdAddr(rdAddr),
		.rdEn(rdEn), .bankSwap(bankSwap), .rdData(orbWord) // data aligned with wordStrobe
	);

endmodule

//--- orbTop_properties.sv
`timescale 1ns/1ps
`include "orbTelemetry_defines.svh"

module orbTopProperties (
	input logic clk100MHz,
	input logic rstN,
	input logic wordStrobe,
	input logic frameStart
);
	localparam int WordGap  = `ORB_WORD_CLKS;     // strobe to strobe
	localparam int FirstGap = `ORB_WORD_CLKS + 1; // reset release to first strobe

	logic [7:0]                gapCnt;            // cycles since reset or last strobe
	logic                      seenStrobe;        // first word already out
	logic [`ORB_SLOT_BITS-1:0] strobeIdx;         // strobes modulo frame length
	logic                      gapFail   = 1'b0;
	logic                      alignFail = 1'b0;
	logic                      phaseFail = 1'b0;
	logic                      anyFail;           // sticky, some property failed

	assign anyFail = gapFail | alignFail | phaseFail;

	always_ff @(posedge clk100MHz) begin
		if (!rstN) begin
			gapCnt     <= '0;
			seenStrobe <= 1'b0;
			strobeIdx  <= '0;
		end else if (wordStrobe) begin
			gapCnt     <= 8'd1; // strobe cycle counts as one
			seenStrobe <= 1'b1;
			strobeIdx  <= strobeIdx + 1'b1; // wraps at 32
		end else if (gapCnt != 8'hff) begin
			gapCnt <= gapCnt + 1'b1; // saturate, long gaps still fail
		end
	end

	// spacing, and nothing before the first word
	strobeGap: assert property (@(posedge clk100MHz) disable iff (!rstN)
		wordStrobe |-> gapCnt == (seenStrobe ? 8'(WordGap) : 8'(FirstGap)))
		else begin
			gapFail <= 1'b1;
			$error("word strobe not on its %0d-cycle grid", WordGap);
		end

	frameAlign: assert property (@(posedge clk100MHz) disable iff (!rstN)
		frameStart |-> wordStrobe)
		else begin
			alignFail <= 1'b1;
			$error("frame start without word strobe");
		end

	// frame start exactly on every 32nd strobe
	framePhase: assert property (@(posedge clk100MHz) disable iff (!rstN)
		wordStrobe |-> frameStart == (strobeIdx == '0))
		else begin
			phaseFail <= 1'b1;
			$error("frame start off slot 0, strobe index %0d", strobeIdx);
		end

endmodule

bind orbTop orbTopProperties uProps (
	.clk100MHz(clk100MHz),
	.rstN(rstN),
	.wordStrobe(wordStrobe),
	.frameStart(frameStart)
);

//--- pingPongRam.sv
`timescale 1ns/1ps
`include "orbTelemetry_defines.svh"

module pingPongRam (
	input  logic                      clk100MHz,
	input  logic                      rstN,
	input  orbPkg::bufWrite_t         bufWr,
	input  logic [`ORB_SLOT_BITS-1:0] rdAddr,
	input  logic                      rdEn,
	input  logic                      bankSwap,
	output logic [`ORB_DATA_BITS-1:0] rdData
);
	localparam int Words = `ORB_FRAME_WORDS;

	logic [`ORB_DATA_BITS-1:0] mem [2][Words]; // two banks
	logic [1:0][Words-1:0]     slotLive;      // slot written since reset
	logic                      wrBank;        // bank the packer fills
	logic                      rdBank;
	logic                      clrPend;       // clear due this cycle
	logic                      clrBank;
	logic [`ORB_SLOT_BITS-1:0] clrAddr;

	assign rdBank = ~wrBank;

	always_ff @(posedge clk100MHz) begin
		if (!rstN) begin
			wrBank   <= 1'b0;
			clrPend  <= 1'b0;
			slotLive <= '0;
			rdData   <= '0;
		end else begin
			clrPend <= rdEn;
			if (rdEn)
				rdData <= slotLive[rdBank][rdAddr] ? mem[rdBank][rdAddr] : '0; // never-written reads zero
			if (bankSwap)
				wrBank <= ~wrBank; // last clear lands on old read bank
			if (bufWr.we)
				slotLive[wrBank][bufWr.addr] <= 1'b1;
		end
	end

	// banks never collide, clear always targets read bank
	always_ff @(posedge clk100MHz) begin
		if (rdEn) begin
			clrAddr <= rdAddr;
			clrBank <= rdBank;
		end
		if (bufWr.we)
			mem[wrBank][bufWr.addr] <= bufWr.data;
		if (clrPend)
			mem[clrBank][clrAddr] <= '0; // read-then-clear
	end

endmodule

//--- project.f
+incdir+.
orbPkg.sv
uartRx.sv
wordAssembler.sv
wordFifo.sv
framePacker.sv
frameTimer.sv
pingPongRam.sv
orbTop.sv
orbTop_properties.sv
orbTb.sv

//--- uartRx.sv
`timescale 1ns/1ps
`include "orbTelemetry_defines.svh"

module uartRx (
	input  logic       clk100MHz,
	input  logic       rstN,
	input  logic       rxLine,
	output logic       byteStrobe,
	output logic [7:0] rxData,
	output logic       frameErr
);
	localparam int BitClks = `ORB_CLKS_PER_BIT;
	localparam int CntW    = $clog2(BitClks);

	typedef enum logic [1:0] {sIdle, sStart, sData, sStop} rxState_t;

	rxState_t        state;
	logic [1:0]      rxSync;   // two-flop synchronizer
	logic            rxPrev;   // for falling edge detect
	logic [CntW-1:0] clkCnt;   // cycles within bit
	logic [2:0]      bitCnt;   // data bit index
	logic [7:0]      shiftReg; // lsb first

	always_ff @(posedge clk100MHz) begin
		if (!rstN) begin
			rxSync     <= 2'b11; // idle line is high
			rxPrev     <= 1'b1;
			state      <= sIdle;
			clkCnt     <= '0;
			bitCnt     <= '0;
			byteStrobe <= 1'b0;
			frameErr   <= 1'b0;
		end else begin
			rxSync     <= {rxSync[0], rxLine};
			rxPrev     <= rxSync[1];
			byteStrobe <= 1'b0;
			frameErr   <= 1'b0;
			clkCnt     <= clkCnt + 1'b1;
			case (state)
				sIdle: begin
					clkCnt <= '0;
					if (rxPrev && !rxSync[1]) state <= sStart; // start edge, not low level
				end
				sStart: begin
					if (clkCnt == CntW'(BitClks / 2 - 1)) begin // middle of start bit
						clkCnt <= '0;
						bitCnt <= '0;
						state  <= rxSync[1] ? sIdle : sData; // glitch, back to idle
					end
				end
				sData: begin
					if (clkCnt == CntW'(BitClks - 1)) begin // middle of data bit
						clkCnt <= '0;
						bitCnt <= bitCnt + 1'b1;
						if (bitCnt == 3'd7) state <= sStop;
					end
				end
				sStop: begin
					if (clkCnt == CntW'(BitClks - 1)) begin
						byteStrobe <= 1'b1;
						frameErr   <= !rxSync[1]; // stop bit must be high
						state      <= sIdle;
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

	// shift register and output byte
	always_ff @(posedge clk100MHz) begin
		if (state == sData && clkCnt == CntW'(BitClks - 1))
			shiftReg <= {rxSync[1], shiftReg[7:1]}; // shift in from msb side
		if (state == sStop && clkCnt == CntW'(BitClks - 1))
			rxData <= shiftReg;
	end

endmodule

//--- wordAssembler.sv
`timescale 1ns/1ps
`include "orbTelemetry_defines.svh"

module wordAssembler #(
	parameter int channel = 0 // selects slot base
) (
	input  logic               clk100MHz,
	input  logic               rstN,
	input  logic               byteStrobe,
	input  logic [7:0]         rxData,
	input  logic               frameErr,
	output logic               fastPush,
	output logic               slowPush,
	output orbPkg::orbSample_t sample
);
	localparam int PacketBytes = 2 * `ORB_PACKET_WORDS;
	localparam int PosW        = $clog2(PacketBytes);
	localparam int IdxW        = $clog2(`ORB_PACKET_WORDS);
	localparam int SlotBase    = channel * `ORB_CHAN_SLOTS;

	logic [PosW-1:0]           bytePos; // byte index in packet
	logic [7:0]                lowByte; // first byte of pair
	logic [IdxW-1:0]           wordIdx;
	logic                      wordDone;

	assign wordIdx  = bytePos[PosW-1:1]; // two bytes per word
	assign wordDone = byteStrobe && !frameErr && bytePos[0];

	always_ff @(posedge clk100MHz) begin
		if (!rstN) begin
			bytePos  <= '0;
			fastPush <= 1'b0;
			slowPush <= 1'b0;
		end else begin
			fastPush <= 1'b0;
			slowPush <= 1'b0;
			if (byteStrobe) begin
				if (frameErr) begin
					bytePos <= '0; // resync to packet start
				end else begin
					if (bytePos == PosW'(PacketBytes - 1))
						bytePos <= '0; // packet complete
					else
						bytePos <= bytePos + 1'b1;
					if (bytePos[0]) begin
						fastPush <= (int'(wordIdx) < `ORB_FAST_WORDS); // leading words fast
						slowPush <= (int'(wordIdx) >= `ORB_FAST_WORDS);
					end
				end
			end
		end
	end

	// payload regs
	always_ff @(posedge clk100MHz) begin
		if (byteStrobe && !frameErr && !bytePos[0])
			lowByte <= rxData;
		if (wordDone) begin
			sample.slot <= `ORB_SLOT_BITS'(SlotBase) + `ORB_SLOT_BITS'(wordIdx);
			sample.data <= {rxData[3:0], lowByte}; // upper nibble dropped
		end
	end

endmodule

//--- wordFifo.sv
`timescale 1ns/1ps
`include "orbTelemetry_defines.svh"

module wordFifo (
	input  logic               clk100MHz,
	input  logic               rstN,
	input  logic               push,
	input  orbPkg::orbSample_t pushData,
	input  logic               pop,
	output orbPkg::orbSample_t head,
	output logic               empty
);
	import orbPkg::*;

	localparam int Depth = `ORB_FIFO_DEPTH;
	localparam int PtrW  = $clog2(Depth);

	orbSample_t      mem [Depth]; // storage
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [PtrW:0]   count;       // occupancy, one extra bit for full
	logic            doPush;
	logic            doPop;

	assign doPush = push && (count != (PtrW + 1)'(Depth)); // drop if full
	assign doPop  = pop && !empty;                          // ignore pop on empty
	assign empty  = (count == '0);
	assign head   = mem[rdPtr]; // show-ahead

	always_ff @(posedge clk100MHz) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	always_ff @(posedge clk100MHz) begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

endmodule
